//--- bench/i2c_reg_tb.sv
//////////////////////////////
// I2C register bank testbench
// Bus master tasks, register model,
// concurrent checks, watchdog
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "i2c_regs_defines.svh"

module i2c_reg_tb;
  import i2c_bus_pkg::*;
  import regfile_pkg::*;

  localparam int unsigned RESET_CYCLES  = 16;
  localparam int unsigned CLK_PERIOD_NS = 20;
  // Data bytes per transaction
  localparam int unsigned WR_LEN   = 5;
  localparam int unsigned MISS_LEN = 3;
  localparam int unsigned PROT_LEN = 4;
  localparam int unsigned LOCK_LEN = 2;
  localparam int unsigned RD_LEN   = 6;
  localparam int unsigned WRAP_LEN = 4;
  // Five writes with address and pointer, two reads with one more address
  localparam int unsigned XFER_CNT = 7;
  localparam int unsigned BYTE_CNT = 5 * 2 + 2 * 3 + WR_LEN + MISS_LEN + PROT_LEN +
                                     LOCK_LEN + RD_LEN + 2 * WRAP_LEN;
  // Start, stop, repeated start, release and bank check cycles
  localparam int unsigned XFER_OVERHEAD = 12;
  localparam int unsigned TOTAL_BITS = RESET_CYCLES + XFER_CNT * XFER_OVERHEAD + 9 * BYTE_CNT;
  localparam int unsigned TIMEOUT_NS = TOTAL_BITS * CLK_PERIOD_NS * 2;

  logic        SCL;
  logic        POR;
  logic        master_sda;
  logic        sda_line;
  logic        sda_out;
  logic        sda_oe;
  dev_addr_t   dev_addr;
  wp_cfg_t     wp_cfg;
  reg_bank_t   init_vals;
  reg_bank_t   regs;
  reg_bank_t   model_bank;
  reg_idx_t    model_ptr;
  // Check enables, each raised for one sampling edge
  logic        ack_chk;
  logic        quiet_chk;
  logic        rd_chk;
  logic        rd_exp;
  logic        release_chk;
  logic        regs_chk;

  // Open-drain line, either side can pull low
  assign sda_line = master_sda & (sda_oe ? sda_out : 1'b1);

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clk (
    .scl_o (SCL),
    .por_o (POR)
  );

  i2c_reg_top u_dut (
    .SCL         (SCL),
    .POR         (POR),
    .sda_i       (sda_line),
    .sda_o       (sda_out),
    .sda_oe_o    (sda_oe),
    .dev_addr_i  (dev_addr),
    .wp_cfg_i    (wp_cfg),
    .init_vals_i (init_vals),
    .regs_o      (regs)
  );

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic raise_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    abort_run();
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_ack_given: assert property (@(posedge SCL) disable iff (!POR)
    ack_chk |-> (sda_oe && !sda_line))
    else raise_error("target did not acknowledge the byte");

  a_bus_quiet: assert property (@(posedge SCL) disable iff (!POR)
    quiet_chk |-> !sda_oe)
    else raise_error("target drove SDA while it should stay off the bus");

  a_read_bit: assert property (@(posedge SCL) disable iff (!POR)
    rd_chk |-> (sda_oe && (sda_line == rd_exp)))
    else raise_error("read bit differs from the register model");

  a_nack_release: assert property (@(posedge SCL) disable iff (!POR)
    release_chk |-> !sda_oe)
    else raise_error("target kept SDA after a master NACK");

  a_bank_match: assert property (@(posedge SCL) disable iff (!POR)
    regs_chk |-> (regs == model_bank))
    else raise_error("register outputs differ from the register model");

  //////////////////////////////
  // Bus master
  //////////////////////////////

  // Falling edge, where every one-shot check drops
  task automatic next_fall();
    @(negedge SCL);
    ack_chk     <= 1'b0;
    rd_chk      <= 1'b0;
    release_chk <= 1'b0;
    regs_chk    <= 1'b0;
  endtask

  task automatic bus_start();
    next_fall();
    master_sda <= 1'b1;
    @(posedge SCL);
    master_sda <= 1'b0;
  endtask

  task automatic bus_stop();
    next_fall();
    master_sda <= 1'b0;
    @(posedge SCL);
    master_sda <= 1'b1;
  endtask

  task automatic send_byte(input bus_byte_t data, input logic ack);
    for (int i = `I2C_DATA_W - 1; i >= 0; i--)
    begin
      next_fall();
      master_sda <= data[i];
      @(posedge SCL);
    end
    next_fall();
    master_sda <= 1'b1;
    ack_chk    <= ack;
    @(posedge SCL);
  endtask

  // Expects the model byte at the pointer, MSB first
  task automatic recv_byte(input logic ack);
    for (int i = `I2C_DATA_W - 1; i >= 0; i--)
    begin
      next_fall();
      master_sda <= 1'b1;
      rd_chk     <= 1'b1;
      rd_exp     <= model_bank[model_ptr][i];
      @(posedge SCL);
    end
    next_fall();
    master_sda <= !ack;
    @(posedge SCL);
    model_ptr = model_ptr + 1'b1;
    if (!ack)
    begin
      next_fall();
      release_chk <= 1'b1;
      @(posedge SCL);
    end
  endtask

  task automatic check_bank();
    next_fall();
    regs_chk <= 1'b1;
    @(posedge SCL);
  endtask

  task automatic write_regs(input dev_addr_t addr, input reg_idx_t ptr,
                            input int unsigned len);
    logic      hit;
    logic      blocked;
    bus_byte_t data;
    hit = (addr == dev_addr);
    quiet_chk <= !hit;
    bus_start();
    send_byte({addr, 1'b0}, hit);
    send_byte(bus_byte_t'(ptr), hit);
    if (hit)
      model_ptr = ptr;
    for (int unsigned n = 0; n < len; n++)
    begin
      data = bus_byte_t'($urandom);
      send_byte(data, hit);
      if (hit)
      begin
        // Locked blocks all, enable blocks indices below range
        blocked = wp_cfg.locked ||
                  (wp_cfg.enable && (int'(model_ptr) < int'(wp_cfg.range)));
        if (!blocked)
          model_bank[model_ptr] = data;
        model_ptr = model_ptr + 1'b1;
      end
    end
    bus_stop();
    quiet_chk <= 1'b0;
    check_bank();
  endtask

  // Pointer write, repeated start, then a read ending in NACK
  task automatic read_regs(input reg_idx_t ptr, input int unsigned len);
    bus_start();
    send_byte({dev_addr, 1'b0}, 1'b1);
    send_byte(bus_byte_t'(ptr), 1'b1);
    model_ptr = ptr;
    bus_start();
    send_byte({dev_addr, 1'b1}, 1'b1);
    for (int unsigned n = 0; n < len; n++)
      recv_byte(n != len - 1);
    bus_stop();
    check_bank();
  endtask

  initial
  begin
    void'($urandom(45));
    master_sda  = 1'b1;
    dev_addr    = 7'h2A;
    wp_cfg      = '0;
    ack_chk     = 1'b0;
    quiet_chk   = 1'b0;
    rd_chk      = 1'b0;
    rd_exp      = 1'b1;
    release_chk = 1'b0;
    regs_chk    = 1'b0;
    model_ptr   = '0;
    for (int i = 0; i < `I2C_NUM_REGS; i++)
      init_vals[i] = reg_data_t'($urandom);
    model_bank = init_vals;

    // Reset values with the pad released
    wait (POR);
    @(posedge SCL);
    quiet_chk <= 1'b1;
    check_bank();
    quiet_chk <= 1'b0;

    write_regs(dev_addr, 5'd4, WR_LEN);
    write_regs(dev_addr ^ 7'h01, 5'd10, MISS_LEN);

    // Indices 6 and 7 below range, 8 and 9 open
    @(posedge SCL);
    wp_cfg.enable <= 1'b1;
    wp_cfg.range  <= 6'd8;
    write_regs(dev_addr, 5'd6, PROT_LEN);
    @(posedge SCL);
    wp_cfg.enable <= 1'b0;
    wp_cfg.locked <= 1'b1;
    write_regs(dev_addr, 5'd20, LOCK_LEN);
    @(posedge SCL);
    wp_cfg <= '0;

    read_regs(5'd3, RD_LEN);
    // Crosses from 31 back to 0
    write_regs(dev_addr, 5'd30, WRAP_LEN);
    read_regs(5'd30, WRAP_LEN);

    next_fall();
    @(posedge SCL);
    $display("Simulation PASSED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("Watchdog expired, the tests did not finish within %0d ns", TIMEOUT_NS);
    abort_run();
  end

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
//////////////////////////////
// Testbench SCL and POR source
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 20,
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic scl_o,
  output logic por_o
);

  initial
  begin
    scl_o = 1'b0;
    por_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge scl_o);
    por_o <= 1'b1;
  end

  // Free-running SCL
  always #(PERIOD_NS / 2) scl_o = ~scl_o;

endmodule

`default_nettype wire

//--- hw/i2c_bus_pkg.sv
//////////////////////////////
// Bus protocol types
// Byte on SDA, device address, target FSM states
//////////////////////////////

`default_nettype none

`include "i2c_regs_defines.svh"

package i2c_bus_pkg;

  // One byte shifted on SDA, MSB first
  typedef logic [`I2C_DATA_W-1:0] bus_byte_t;

  // Device address compared against the first byte
  typedef logic [`I2C_DEV_ADDR_W-1:0] dev_addr_t;

  // Target phases, each *_ACK state spans the 9th bit of a byte
  typedef enum logic [3:0] {
    IDLE,
    ADDR,
    ADDR_ACK,
    PTR,
    PTR_ACK,
    WDATA,
    WDATA_ACK,
    RDATA,
    RDATA_ACK
  } target_state_e;

endpackage

`default_nettype wire

//--- hw/i2c_reg_top.sv
//////////////////////////////
// I2C register bank top level
// Target FSM, slice array, read mux
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "i2c_regs_defines.svh"

module i2c_reg_top (
  input  logic                   SCL,
  input  logic                   POR,
  input  logic                   sda_i,
  output logic                   sda_o,
  output logic                   sda_oe_o,
  input  i2c_bus_pkg::dev_addr_t dev_addr_i,
  input  regfile_pkg::wp_cfg_t   wp_cfg_i,
  input  regfile_pkg::reg_bank_t init_vals_i,
  output regfile_pkg::reg_bank_t regs_o
);
  import regfile_pkg::*;

  reg_wr_t   wr_req;
  reg_idx_t  rd_ptr;
  reg_data_t rd_data;

  i2c_target_fsm u_target (
    .SCL        (SCL),
    .POR        (POR),
    .sda_i      (sda_i),
    .dev_addr_i (dev_addr_i),
    .wp_cfg_i   (wp_cfg_i),
    .rd_data_i  (rd_data),
    .wr_req_o   (wr_req),
    .rd_ptr_o   (rd_ptr),
    .sda_o      (sda_o),
    .sda_oe_o   (sda_oe_o)
  );

  // Each slice decodes its own index from the shared request
  for (genvar g = 0; g < `I2C_NUM_REGS; g++)
  begin : g_slice
    reg_slice #(
      .SLICE_IDX (g)
    ) u_slice (
      .SCL      (SCL),
      .POR      (POR),
      .init_i   (init_vals_i[g]),
      .wr_req_i (wr_req),
      .value_o  (regs_o[g])
    );
  end

  reg_read_mux u_rd_mux (
    .bank_i    (regs_o),
    .rd_ptr_i  (rd_ptr),
    .rd_data_o (rd_data)
  );

endmodule

`default_nettype wire

//--- hw/i2c_target_fsm.sv
//////////////////////////////
// I2C target protocol engine
// Start/stop detection, address match, acknowledge,
// register pointer, write protection, read shifter
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "i2c_regs_defines.svh"

module i2c_target_fsm (
  input  logic                   SCL,
  input  logic                   POR,
  input  logic                   sda_i,
  input  i2c_bus_pkg::dev_addr_t dev_addr_i,
  input  regfile_pkg::wp_cfg_t   wp_cfg_i,
  input  regfile_pkg::reg_data_t rd_data_i,
  output regfile_pkg::reg_wr_t   wr_req_o,
  output regfile_pkg::reg_idx_t  rd_ptr_o,
  output logic                   sda_o,
  output logic                   sda_oe_o
);
  import i2c_bus_pkg::*;
  import regfile_pkg::*;

  localparam int unsigned      CNT_W    = $clog2(`I2C_DATA_W);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`I2C_DATA_W - 1);

  target_state_e    state_q;
  logic [CNT_W-1:0] bit_cnt_q;
  bus_byte_t        shift_q;
  bus_byte_t        rx_byte;
  bus_byte_t        tx_q;
  logic             rw_q;
  reg_idx_t         ptr_q;
  reg_wr_t          wr_req_q;
  logic             sda_oe_q;
  logic             last_bit;
  logic             addr_hit;
  logic             wp_block;
  logic             start_det_q;
  logic             start_seen_q;
  logic             stop_det_q;
  logic             stop_seen_q;
  logic             start_rst;
  logic             stop_rst;

  //////////////////////////////
  // Start and stop detection
  //////////////////////////////

  // Detector flops are held clear until the next SCL fall
  assign start_rst = ~POR | start_seen_q;
  assign stop_rst  = ~POR | stop_seen_q;

  always_ff @(negedge sda_i or posedge start_rst)
  begin
    if (start_rst)
      start_det_q <= 1'b0;
    else
      start_det_q <= SCL;
  end

  always_ff @(posedge sda_i or posedge stop_rst)
  begin
    if (stop_rst)
      stop_det_q <= 1'b0;
    else
      stop_det_q <= SCL;
  end

  always_ff @(negedge SCL or negedge POR)
  begin
    if (!POR)
    begin
      start_seen_q <= 1'b0;
      stop_seen_q  <= 1'b0;
    end
    else
    begin
      start_seen_q <= start_det_q;
      stop_seen_q  <= stop_det_q;
    end
  end

  //////////////////////////////
  // Receive side, rising edge
  //////////////////////////////

  assign rx_byte  = {shift_q[`I2C_DATA_W-2:0], sda_i};
  assign last_bit = (bit_cnt_q == LAST_BIT);
  assign addr_hit = (rx_byte[`I2C_DATA_W-1:1] == dev_addr_i);

  // Locked blocks all writes, enable blocks the low part of the bank
  assign wp_block = wp_cfg_i.locked |
                    (wp_cfg_i.enable & ({1'b0, ptr_q} < wp_cfg_i.range));

  always_ff @(posedge SCL or negedge POR)
  begin
    if (!POR)
    begin
      state_q   <= IDLE;
      bit_cnt_q <= '0;
      shift_q   <= '0;
      rw_q      <= 1'b0;
      ptr_q     <= '0;
      wr_req_q  <= '0;
    end
    else
    begin
      wr_req_q.valid <= 1'b0;
      if (start_seen_q)
      begin
        // First address bit arrives on this edge
        state_q   <= ADDR;
        shift_q   <= rx_byte;
        bit_cnt_q <= CNT_W'(1);
      end
      else if (stop_seen_q)
      begin
        state_q   <= IDLE;
        bit_cnt_q <= '0;
      end
      else
      begin
        case (state_q)
          ADDR:
          begin
            shift_q   <= rx_byte;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (last_bit)
            begin
              rw_q    <= rx_byte[0];
              state_q <= addr_hit ? ADDR_ACK : IDLE;
            end
          end
          ADDR_ACK:
            state_q <= rw_q ? RDATA : PTR;
          PTR:
          begin
            shift_q   <= rx_byte;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (last_bit)
            begin
              ptr_q   <= rx_byte[`I2C_PTR_W-1:0];
              state_q <= PTR_ACK;
            end
          end
          PTR_ACK:
            state_q <= WDATA;
          WDATA:
          begin
            shift_q   <= rx_byte;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (last_bit)
            begin
              wr_req_q.valid <= ~wp_block;
              wr_req_q.idx   <= ptr_q;
              wr_req_q.data  <= rx_byte;
              ptr_q          <= ptr_q + 1'b1;
              state_q        <= WDATA_ACK;
            end
          end
          WDATA_ACK:
            state_q <= WDATA;
          RDATA:
          begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (last_bit)
            begin
              ptr_q   <= ptr_q + 1'b1;
              state_q <= RDATA_ACK;
            end
          end
          // High here is a master NACK, wait for the next start
          RDATA_ACK:
            state_q <= sda_i ? IDLE : RDATA;
          default:
            bit_cnt_q <= '0;
        endcase
      end
    end
  end

  //////////////////////////////
  // Drive side, falling edge
  //////////////////////////////

  // Acknowledge is a zero loaded into the output shifter
  always_ff @(negedge SCL or negedge POR)
  begin
    if (!POR)
    begin
      sda_oe_q <= 1'b0;
      tx_q     <= '1;
    end
    else if (start_det_q | stop_det_q)
    begin
      sda_oe_q <= 1'b0;
      tx_q     <= '1;
    end
    else
    begin
      case (state_q)
        ADDR_ACK, PTR_ACK, WDATA_ACK:
        begin
          sda_oe_q <= 1'b1;
          tx_q     <= '0;
        end
        RDATA:
        begin
          sda_oe_q <= 1'b1;
          if (bit_cnt_q == '0)
            tx_q <= rd_data_i;
          else
            tx_q <= {tx_q[`I2C_DATA_W-2:0], 1'b1};
        end
        default:
        begin
          sda_oe_q <= 1'b0;
          tx_q     <= '1;
        end
      endcase
    end
  end

  assign sda_o    = tx_q[`I2C_DATA_W-1];
  assign sda_oe_o = sda_oe_q;
  assign wr_req_o = wr_req_q;
  assign rd_ptr_o = ptr_q;

  // Pad released whenever the FSM rests
  a_idle_released: assert property (@(posedge SCL) disable iff (!POR)
    (state_q == IDLE) |-> !sda_oe_o);

  // One request per received byte
  a_wr_single: assert property (@(posedge SCL) disable iff (!POR)
    wr_req_o.valid |=> !wr_req_o.valid);

endmodule

`default_nettype wire

//--- hw/reg_read_mux.sv
//////////////////////////////
// Read-back selector
// Picks the byte at the read pointer
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module reg_read_mux (
  input  regfile_pkg::reg_bank_t bank_i,
  input  regfile_pkg::reg_idx_t  rd_ptr_i,
  output regfile_pkg::reg_data_t rd_data_o
);
  import regfile_pkg::*;

  reg_data_t sel_data;

  // Pure combinational select, no added latency
  always_comb
  begin
    sel_data = bank_i[rd_ptr_i];
  end

  // Feeds the target's output shifter
  assign rd_data_o = sel_data;

endmodule

`default_nettype wire

//--- hw/reg_slice.sv
//////////////////////////////
// One control register
// Reset value from input, own index decode
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module reg_slice #(
  parameter int unsigned SLICE_IDX = 0
) (
  input  logic                   SCL,
  input  logic                   POR,
  input  regfile_pkg::reg_data_t init_i,
  input  regfile_pkg::reg_wr_t   wr_req_i,
  output regfile_pkg::reg_data_t value_o
);
  import regfile_pkg::*;

  reg_data_t value_q;
  logic      hit;

  // Request addressed to this slice
  assign hit = wr_req_i.valid && (wr_req_i.idx == reg_idx_t'(SLICE_IDX));

  always_ff @(posedge SCL or negedge POR)
  begin
    if (!POR)
      value_q <= init_i;
    else if (hit)
      value_q <= wr_req_i.data;
  end

  assign value_o = value_q;

endmodule

`default_nettype wire

//--- hw/regfile_pkg.sv
//////////////////////////////
// Register bank types
// Index, data, write request, protection config, bank
//////////////////////////////

`default_nettype none

`include "i2c_regs_defines.svh"

package regfile_pkg;

  typedef logic [`I2C_PTR_W-1:0]  reg_idx_t;
  typedef logic [`I2C_DATA_W-1:0] reg_data_t;

  // Write request broadcast to every slice
  typedef struct packed {
    logic      valid;
    reg_idx_t  idx;
    reg_data_t data;
  } reg_wr_t;

  // Range carries one extra bit so a value of 32 covers the whole bank
  typedef struct packed {
    logic                 enable;
    logic                 locked;
    logic [`I2C_PTR_W:0]  range;
  } wp_cfg_t;

  // All register values, index 0 in the low byte
  typedef reg_data_t [`I2C_NUM_REGS-1:0] reg_bank_t;

endpackage

`default_nettype wire

//--- include/i2c_regs_defines.svh
//////////////////////////////
// Sizing macros for the I2C register bank
// Register count, byte width, index and device address widths
//////////////////////////////

`ifndef I2C_REGS_DEFINES_SVH
`define I2C_REGS_DEFINES_SVH

// Number of registers in the bank
`define I2C_NUM_REGS 32

// Bits per register and per bus byte
`define I2C_DATA_W 8

// Register index width, enough for I2C_NUM_REGS
`define I2C_PTR_W 5

// 7-bit I2C device address
`define I2C_DEV_ADDR_W 7

`endif

//--- run.sh
#!/bin/sh
# Build and run the I2C register bank testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module i2c_reg_tb -f src.f -o sim_tb

# The log decides the result, so a stopped run still reaches the search
./obj_dir/sim_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Simulation PASSED" "$LOG"; then
  exit 0
fi
exit 1

//--- src.f
+incdir+include
hw/i2c_bus_pkg.sv
hw/regfile_pkg.sv
hw/i2c_target_fsm.sv
hw/reg_slice.sv
hw/reg_read_mux.sv
hw/i2c_reg_top.sv
bench/tb_clock_gen.sv
bench/i2c_reg_tb.sv
